// ==== include/e31x_cfg.svh ====
/*
  Widths, buffer depths and register map of the radio glue logic.
  Included by the package and by every module that needs a constant.
*/
`ifndef E31X_CFG_SVH
`define E31X_CFG_SVH

// Sample and channel word layout
`define E31X_SAMPLE_W        12
`define E31X_PAD_W           4
`define E31X_NUM_CHANNELS    2

// Register port
`define E31X_REG_AW          2
`define E31X_REG_DW          32

// Stream buffers and credit counters
`define E31X_RX_FIFO_DEPTH   4
`define E31X_TX_BUF_DEPTH    4
`define E31X_CREDIT_W        3

// Resynchroniser and PPS delay line
`define E31X_SYNC_STAGES     2
`define E31X_PPS_STAGES      3

// Register addresses
`define E31X_ADDR_CTRL       2'd0
`define E31X_ADDR_STATUS     2'd1
`define E31X_ADDR_LEDS       2'd2

`endif

// ==== src/e31x_pkg.sv ====
/*
  Vector types shared by the radio glue RTL and its testbench.
  Compile first; modules refer to it by scoped names and wildcard import.
*/
`default_nettype none

`include "e31x_cfg.svh"

package e31x_pkg;

  // One I or Q sample from the codec
  typedef logic [`E31X_SAMPLE_W-1:0] sample_t;

  // I in the top sample field, Q in the lower one, zero pad below each
  typedef logic [2*(`E31X_SAMPLE_W+`E31X_PAD_W)-1:0] chan_word_t;

  // Both channels, channel 1 in the upper half
  typedef logic [`E31X_NUM_CHANNELS*2*(`E31X_SAMPLE_W+`E31X_PAD_W)-1:0] sample_word_t;

  // Register port
  typedef logic [`E31X_REG_AW-1:0] reg_addr_t;
  typedef logic [`E31X_REG_DW-1:0] reg_data_t;

  typedef logic [`E31X_CREDIT_W-1:0] credit_t;

endpackage

`default_nettype wire

// ==== src/e31x_ctrl_regs.sv ====
/*
  Control and status registers behind a simple register port.
  Writes take effect at once, reads return registered data one cycle later.
  Holds the mimo and codec reset bits, the LED bits and the sticky
  stream error flags.
*/
`default_nettype none

`include "e31x_cfg.svh"

module e31x_ctrl_regs (
  input  logic                bus_clk,
  input  logic                reset,
  input  logic                reg_wr_en,
  input  e31x_pkg::reg_addr_t reg_wr_addr,
  input  e31x_pkg::reg_data_t reg_wr_data,
  input  logic                reg_rd_en,
  input  e31x_pkg::reg_addr_t reg_rd_addr,
  output e31x_pkg::reg_data_t reg_rd_data,
  input  logic [5:0]          status_bits,
  input  logic                rx_overflow_pulse,
  input  logic                tx_underrun_pulse,
  output logic                mimo,
  output logic                codec_reset,
  output logic [5:0]          leds
);

  import e31x_pkg::*;

  logic [1:0] ctrl_q;
  logic [5:0] leds_q;
  logic       rx_overflow_flag;
  logic       tx_underrun_flag;
  logic       wr_ctrl;
  logic       wr_status;
  logic       wr_leds;
  reg_data_t  status_word;
  reg_data_t  rd_next;

  assign wr_ctrl   = reg_wr_en && (reg_wr_addr == `E31X_ADDR_CTRL);
  assign wr_status = reg_wr_en && (reg_wr_addr == `E31X_ADDR_STATUS);
  assign wr_leds   = reg_wr_en && (reg_wr_addr == `E31X_ADDR_LEDS);

  ////////////////////
  // Writable registers
  ////////////////////

  // Boots with mimo on and the codec out of reset
  always_ff @(posedge bus_clk) begin
    if (reset) begin
      ctrl_q <= 2'b01;
      leds_q <= '0;
    end else begin
      if (wr_ctrl)
        ctrl_q <= reg_wr_data[1:0];
      if (wr_leds)
        leds_q <= reg_wr_data[5:0];
    end
  end

  // Sticky flags, a new error wins over a clear in the same cycle
  always_ff @(posedge bus_clk) begin
    if (reset) begin
      rx_overflow_flag <= 1'b0;
      tx_underrun_flag <= 1'b0;
    end else begin
      if (rx_overflow_pulse)
        rx_overflow_flag <= 1'b1;
      else if (wr_status && reg_wr_data[0])
        rx_overflow_flag <= 1'b0;
      if (tx_underrun_pulse)
        tx_underrun_flag <= 1'b1;
      else if (wr_status && reg_wr_data[1])
        tx_underrun_flag <= 1'b0;
    end
  end

  ////////////////////
  // Readback
  ////////////////////

  // Ref status in 11:8, PLL locks in 7:6
  always_comb begin
    status_word       = '0;
    status_word[11:6] = status_bits;
    status_word[1]    = tx_underrun_flag;
    status_word[0]    = rx_overflow_flag;
  end

  always_comb begin
    rd_next = '0;
    case (reg_rd_addr)
      `E31X_ADDR_CTRL:   rd_next[1:0] = ctrl_q;
      `E31X_ADDR_STATUS: rd_next = status_word;
      `E31X_ADDR_LEDS:   rd_next[5:0] = leds_q;
      default:           rd_next = '0;
    endcase
  end

  always_ff @(posedge bus_clk) begin
    if (reset)
      reg_rd_data <= '0;
    else if (reg_rd_en)
      reg_rd_data <= rd_next;
  end

  assign mimo        = ctrl_q[0];
  assign codec_reset = ctrl_q[1];
  assign leds        = leds_q;

endmodule

`default_nettype wire

// ==== src/e31x_status_sync.sv ====
/*
  Brings the reference status and codec PLL lock bits onto bus_clk,
  and delays GPS PPS onto a GPIO for time daemons on the host.
*/
`default_nettype none

`include "e31x_cfg.svh"

module e31x_status_sync (
  input  logic       bus_clk,
  input  logic       reset,
  input  logic [3:0] ref_status,
  input  logic       tx_pll_lock,
  input  logic       rx_pll_lock,
  input  logic       gps_pps,
  output logic [5:0] status_bits,
  output logic       pps_gpio
);

  localparam int SYNC_STAGES = `E31X_SYNC_STAGES;
  localparam int PPS_STAGES  = `E31X_PPS_STAGES;

  logic [SYNC_STAGES-1:0][5:0] sync_q;
  logic [PPS_STAGES-1:0]       pps_shift;

  ////////////////////
  // Status resync
  ////////////////////

  // Layout matches STATUS bits 11:6
  always_ff @(posedge bus_clk) begin
    sync_q[0] <= {ref_status, tx_pll_lock, rx_pll_lock};
    for (int i = 1; i < SYNC_STAGES; i++) begin
      sync_q[i] <= sync_q[i-1];
    end
  end

  assign status_bits = sync_q[SYNC_STAGES-1];

  ////////////////////
  // PPS delay line
  ////////////////////

  always_ff @(posedge bus_clk) begin
    if (reset)
      pps_shift <= '0;
    else
      pps_shift <= {pps_shift[PPS_STAGES-2:0], gps_pps};
  end

  assign pps_gpio = pps_shift[PPS_STAGES-1];

endmodule

`default_nettype wire

// ==== src/e31x_rx_packer.sv ====
/*
  Packs codec receive samples into padded two-channel words, buffers them
  and hands them out one word per credit from the consumer.
  A strobe that finds the buffer full is dropped and reported.
*/
`default_nettype none

`include "e31x_cfg.svh"

module e31x_rx_packer #(
  parameter int DEPTH = `E31X_RX_FIFO_DEPTH
) (
  input  logic                   bus_clk,
  input  logic                   reset,
  input  logic                   mimo,
  input  logic                   rx_stb,
  input  e31x_pkg::sample_t      rx_a_i,
  input  e31x_pkg::sample_t      rx_a_q,
  input  e31x_pkg::sample_t      rx_b_i,
  input  e31x_pkg::sample_t      rx_b_q,
  input  logic                   rx_credit,
  output logic                   rx_valid,
  output e31x_pkg::sample_word_t rx_data,
  output logic                   rx_overflow_pulse
);

  import e31x_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam credit_t CREDIT_MAX = credit_t'(DEPTH);

  sample_word_t     buf_mem [DEPTH];
  chan_word_t       ch0_word;
  chan_word_t       ch1_word;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;
  credit_t          credits;
  logic             full;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Port A feeds channel 1, port B channel 0
  assign ch1_word = mimo ? {rx_a_i, {`E31X_PAD_W{1'b0}}, rx_a_q, {`E31X_PAD_W{1'b0}}} : '0;
  assign ch0_word = {rx_b_i, {`E31X_PAD_W{1'b0}}, rx_b_q, {`E31X_PAD_W{1'b0}}};

  assign full = (fill == CNT_W'(DEPTH));
  assign push = rx_stb && !full;
  assign pop  = rx_valid;

  assign rx_overflow_pulse = rx_stb && full;
  assign rx_valid = (fill != '0) && (credits != '0);
  assign rx_data  = buf_mem[rd_ptr];

  always_ff @(posedge bus_clk) begin
    if (push)
      buf_mem[wr_ptr] <= {ch1_word, ch0_word};
  end

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      fill    <= '0;
      credits <= '0;
    end else begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // Credits saturate at the buffer depth
      case ({rx_credit, pop})
        2'b10:   credits <= (credits == CREDIT_MAX) ? credits : credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/e31x_tx_unpacker.sv ====
/*
  Buffers credited transmit words and unpacks the oldest one into codec
  I/Q on every transmit strobe, returning one credit per word used.
  A strobe on an empty buffer sends zeros and reports an underrun.
*/
`default_nettype none

`include "e31x_cfg.svh"

module e31x_tx_unpacker #(
  parameter int DEPTH = `E31X_TX_BUF_DEPTH
) (
  input  logic                   bus_clk,
  input  logic                   reset,
  input  logic                   mimo,
  input  logic                   tx_valid,
  input  e31x_pkg::sample_word_t tx_data,
  input  logic                   tx_stb,
  output e31x_pkg::sample_t      tx_a_i,
  output e31x_pkg::sample_t      tx_a_q,
  output e31x_pkg::sample_t      tx_b_i,
  output e31x_pkg::sample_t      tx_b_q,
  output logic                   tx_credit,
  output logic                   tx_underrun_pulse
);

  import e31x_pkg::*;

  localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int HALF_W = `E31X_SAMPLE_W + `E31X_PAD_W;
  localparam int SMP_W  = `E31X_SAMPLE_W;

  sample_word_t     buf_mem [DEPTH];
  chan_word_t       ch0_word;
  chan_word_t       ch1_word;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;
  logic             empty;
  logic             full;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty = (fill == '0);
  assign full  = (fill == CNT_W'(DEPTH));
  assign push  = tx_valid && !full;
  assign pop   = tx_stb && !empty;

  assign tx_underrun_pulse = tx_stb && empty;
  assign {ch1_word, ch0_word} = buf_mem[rd_ptr];

  always_ff @(posedge bus_clk) begin
    if (push)
      buf_mem[wr_ptr] <= tx_data;
  end

  // Channel 1 drives port A, silenced when mimo is off
  always_ff @(posedge bus_clk) begin
    if (tx_stb) begin
      if (empty) begin
        tx_a_i <= '0;
        tx_a_q <= '0;
        tx_b_i <= '0;
        tx_b_q <= '0;
      end else begin
        tx_a_i <= mimo ? ch1_word[2*HALF_W-1 -: SMP_W] : '0;
        tx_a_q <= mimo ? ch1_word[HALF_W-1 -: SMP_W] : '0;
        tx_b_i <= ch0_word[2*HALF_W-1 -: SMP_W];
        tx_b_q <= ch0_word[HALF_W-1 -: SMP_W];
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fill      <= '0;
      tx_credit <= 1'b0;
    end else begin
      tx_credit <= pop;
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/e31x_radio_glue.sv ====
/*
  Fabric-side glue of the two-channel radio top level on bus_clk.
  Ties the register block, status resync, receive packer and transmit
  unpacker together and drives the LEDs and the codec reset.
*/
`default_nettype none

module e31x_radio_glue (
  input  logic                   bus_clk,
  input  logic                   reset,
  // Register port
  input  logic                   reg_wr_en,
  input  e31x_pkg::reg_addr_t    reg_wr_addr,
  input  e31x_pkg::reg_data_t    reg_wr_data,
  input  logic                   reg_rd_en,
  input  e31x_pkg::reg_addr_t    reg_rd_addr,
  output e31x_pkg::reg_data_t    reg_rd_data,
  // Receive samples and stream
  input  logic                   rx_stb,
  input  e31x_pkg::sample_t      rx_a_i,
  input  e31x_pkg::sample_t      rx_a_q,
  input  e31x_pkg::sample_t      rx_b_i,
  input  e31x_pkg::sample_t      rx_b_q,
  input  logic                   rx_credit,
  output logic                   rx_valid,
  output e31x_pkg::sample_word_t rx_data,
  // Transmit stream and samples
  input  logic                   tx_valid,
  input  e31x_pkg::sample_word_t tx_data,
  input  logic                   tx_stb,
  output e31x_pkg::sample_t      tx_a_i,
  output e31x_pkg::sample_t      tx_a_q,
  output e31x_pkg::sample_t      tx_b_i,
  output e31x_pkg::sample_t      tx_b_q,
  output logic                   tx_credit,
  // Reference, codec and PPS
  input  logic [3:0]             ref_status,
  input  logic                   tx_pll_lock,
  input  logic                   rx_pll_lock,
  input  logic                   gps_pps,
  output logic                   pps_gpio,
  output logic                   cat_reset_n,
  // LEDs
  output logic                   led_rx1_rx,
  output logic                   led_txrx1_tx,
  output logic                   led_txrx1_rx,
  output logic                   led_rx2_rx,
  output logic                   led_txrx2_tx,
  output logic                   led_txrx2_rx
);

  logic [5:0] status_bits;
  logic [5:0] leds;
  logic       mimo;
  logic       codec_reset;
  logic       rx_overflow_pulse;
  logic       tx_underrun_pulse;

  e31x_ctrl_regs ctrl_regs_i (
    .bus_clk           (bus_clk),
    .reset             (reset),
    .reg_wr_en         (reg_wr_en),
    .reg_wr_addr       (reg_wr_addr),
    .reg_wr_data       (reg_wr_data),
    .reg_rd_en         (reg_rd_en),
    .reg_rd_addr       (reg_rd_addr),
    .reg_rd_data       (reg_rd_data),
    .status_bits       (status_bits),
    .rx_overflow_pulse (rx_overflow_pulse),
    .tx_underrun_pulse (tx_underrun_pulse),
    .mimo              (mimo),
    .codec_reset       (codec_reset),
    .leds              (leds)
  );

  e31x_status_sync status_sync_i (
    .bus_clk     (bus_clk),
    .reset       (reset),
    .ref_status  (ref_status),
    .tx_pll_lock (tx_pll_lock),
    .rx_pll_lock (rx_pll_lock),
    .gps_pps     (gps_pps),
    .status_bits (status_bits),
    .pps_gpio    (pps_gpio)
  );

  e31x_rx_packer rx_packer_i (
    .bus_clk           (bus_clk),
    .reset             (reset),
    .mimo              (mimo),
    .rx_stb            (rx_stb),
    .rx_a_i            (rx_a_i),
    .rx_a_q            (rx_a_q),
    .rx_b_i            (rx_b_i),
    .rx_b_q            (rx_b_q),
    .rx_credit         (rx_credit),
    .rx_valid          (rx_valid),
    .rx_data           (rx_data),
    .rx_overflow_pulse (rx_overflow_pulse)
  );

  e31x_tx_unpacker tx_unpacker_i (
    .bus_clk           (bus_clk),
    .reset             (reset),
    .mimo              (mimo),
    .tx_valid          (tx_valid),
    .tx_data           (tx_data),
    .tx_stb            (tx_stb),
    .tx_a_i            (tx_a_i),
    .tx_a_q            (tx_a_q),
    .tx_b_i            (tx_b_i),
    .tx_b_q            (tx_b_q),
    .tx_credit         (tx_credit),
    .tx_underrun_pulse (tx_underrun_pulse)
  );

  // Channel 1 lights the "1" LEDs, channel 0 the "2" LEDs
  assign {led_rx1_rx, led_txrx1_tx, led_txrx1_rx} = leds[5:3];
  assign {led_rx2_rx, led_txrx2_tx, led_txrx2_rx} = leds[2:0];

  // Codec reset pin is active low
  assign cat_reset_n = ~(reset | codec_reset);

endmodule

`default_nettype wire

// ==== testbench/e31x_tb.sv ====
/*
  Testbench for the radio glue top level.
  Covers registers, LEDs, codec reset, status resync, the PPS delay and
  both credit-based sample streams against models of the word layout.
*/
`default_nettype none

`include "e31x_cfg.svh"

module e31x_tb;

  import e31x_pkg::*;

  localparam int RX_DEPTH    = `E31X_RX_FIFO_DEPTH;
  localparam int TX_DEPTH    = `E31X_TX_BUF_DEPTH;
  localparam int PAD_W       = `E31X_PAD_W;
  localparam int RX_WORDS    = 40;
  localparam int TX_CYCLES   = 60;
  localparam int DRAIN_LIMIT = 50;
  // Cycle budget of all phases, doubled for margin
  localparam int RUN_CYCLES  = 2 * (100 + 6 * RX_WORDS + 3 * DRAIN_LIMIT + 3 * TX_CYCLES);

  logic         bus_clk;
  logic         reset;
  logic         reg_wr_en;
  reg_addr_t    reg_wr_addr;
  reg_data_t    reg_wr_data;
  logic         reg_rd_en;
  reg_addr_t    reg_rd_addr;
  reg_data_t    reg_rd_data;
  logic         rx_stb;
  sample_t      rx_a_i;
  sample_t      rx_a_q;
  sample_t      rx_b_i;
  sample_t      rx_b_q;
  logic         rx_credit;
  logic         rx_valid;
  sample_word_t rx_data;
  logic         tx_valid;
  sample_word_t tx_data;
  logic         tx_stb;
  sample_t      tx_a_i;
  sample_t      tx_a_q;
  sample_t      tx_b_i;
  sample_t      tx_b_q;
  logic         tx_credit;
  logic [3:0]   ref_status;
  logic         tx_pll_lock;
  logic         rx_pll_lock;
  logic         gps_pps;
  logic         pps_gpio;
  logic         cat_reset_n;
  logic         led_rx1_rx;
  logic         led_txrx1_tx;
  logic         led_txrx1_rx;
  logic         led_rx2_rx;
  logic         led_txrx2_tx;
  logic         led_txrx2_rx;

  // Model state
  sample_word_t rx_model[$];
  sample_word_t tx_model[$];
  sample_word_t exp_word;
  sample_word_t tx_word;
  logic [47:0]  tx_exp;
  logic         tx_check = 1'b0;
  logic         tx_credit_exp = 1'b0;
  logic         rx_full;
  logic [2:0]   pps_hist = '0;
  logic         mimo_on = 1'b1;
  int           rx_credits = 0;
  int           tx_credits = TX_DEPTH;

  e31x_radio_glue dut (.*);

  initial bus_clk = 1'b0;
  always #5 bus_clk = ~bus_clk;

  task automatic abort_run(input string reason);
    $display("Test failed");
    $fatal(1, "%s", reason);
  endtask

  task automatic report_mismatch(input string msg);
    $display("mismatch at time %0t: %s", $time, msg);
    abort_run("value mismatch");
  endtask

  initial begin
    #(RUN_CYCLES * 10);
    abort_run("timeout, the run did not finish in its time budget");
  end

  // Padded layout, port A to channel 1 in the upper half
  function automatic sample_word_t pack_sample(input logic mimo_bit, input sample_t a_i,
                                               input sample_t a_q, input sample_t b_i,
                                               input sample_t b_q);
    chan_word_t ch1;
    chan_word_t ch0;
    ch1 = {a_i, {PAD_W{1'b0}}, a_q, {PAD_W{1'b0}}};
    ch0 = {b_i, {PAD_W{1'b0}}, b_q, {PAD_W{1'b0}}};
    if (!mimo_bit)
      ch1 = '0;
    return {ch1, ch0};
  endfunction

  // Ports in the order {a_i, a_q, b_i, b_q}
  function automatic logic [47:0] unpack_word(input logic mimo_bit, input sample_word_t w);
    logic [47:0] ports;
    ports = {w[63:52], w[47:36], w[31:20], w[15:4]};
    if (!mimo_bit)
      ports[47:24] = '0;
    return ports;
  endfunction

  ////////////////////
  // Monitors
  ////////////////////

  always @(negedge bus_clk) begin
    if (!reset) begin
      assert (pps_gpio === pps_hist[2]) else report_mismatch("pps_gpio is not PPS delayed 3");
      // Full is judged before this cycle's pop
      rx_full = (rx_model.size() == RX_DEPTH);
      if (rx_valid) begin
        assert (rx_credits > 0) else report_mismatch("rx_valid with no credit held");
        assert (rx_model.size() > 0) else report_mismatch("rx_valid with no word buffered");
        exp_word = rx_model.pop_front();
        assert (rx_data === exp_word) else report_mismatch("rx_data differs from model");
        rx_credits--;
      end
      if (rx_credit)
        rx_credits++;
      if (rx_stb && !rx_full)
        rx_model.push_back(pack_sample(mimo_on, rx_a_i, rx_a_q, rx_b_i, rx_b_q));
      assert (tx_credit === tx_credit_exp) else report_mismatch("tx_credit pulse wrong");
      if (tx_check)
        assert ({tx_a_i, tx_a_q, tx_b_i, tx_b_q} === tx_exp)
          else report_mismatch("tx ports differ from unpacked word");
      tx_check = tx_stb;
      tx_credit_exp = 1'b0;
      if (tx_stb) begin
        if (tx_model.size() == 0) begin
          tx_exp = '0;
        end else begin
          tx_word = tx_model.pop_front();
          tx_exp = unpack_word(mimo_on, tx_word);
          tx_credit_exp = 1'b1;
        end
      end
      if (tx_credit)
        tx_credits++;
      if (tx_valid)
        tx_model.push_back(tx_data);
    end
    pps_hist = {pps_hist[1:0], gps_pps};
  end

  ////////////////////
  // Bus tasks
  ////////////////////

  // Next drive point, PPS toggles randomly alongside
  task automatic step();
    @(posedge bus_clk);
    #1;
    gps_pps = 1'($urandom);
  endtask

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    reg_wr_en   = 1'b1;
    reg_wr_addr = addr;
    reg_wr_data = data;
    step();
    reg_wr_en = 1'b0;
    if (addr == `E31X_ADDR_CTRL)
      mimo_on = data[0];
  endtask

  task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
    reg_rd_en   = 1'b1;
    reg_rd_addr = addr;
    step();
    reg_rd_en = 1'b0;
    data = reg_rd_data;
  endtask

  task automatic check_reg(input reg_addr_t addr, input reg_data_t mask, input reg_data_t exp,
                           input string msg);
    reg_data_t data;
    read_reg(addr, data);
    assert ((data & mask) === exp) else report_mismatch(msg);
  endtask

  ////////////////////
  // Test phases
  ////////////////////

  task automatic check_regs_and_leds();
    reg_data_t  data;
    logic [5:0] leds;
    leds = {led_rx1_rx, led_txrx1_tx, led_txrx1_rx, led_rx2_rx, led_txrx2_tx, led_txrx2_rx};
    assert (leds === 6'd0) else report_mismatch("LED outputs not off after reset");
    check_reg(`E31X_ADDR_CTRL, '1, 32'd1, "CTRL reset value");
    check_reg(`E31X_ADDR_LEDS, '1, 32'd0, "LEDS reset value");
    check_reg(`E31X_ADDR_STATUS, 32'h3, 32'd0, "sticky flags after reset");
    check_reg(2'd3, '1, 32'd0, "unmapped address not zero");
    repeat (8) begin
      data = $urandom;
      write_reg(`E31X_ADDR_LEDS, data);
      leds = {led_rx1_rx, led_txrx1_tx, led_txrx1_rx, led_rx2_rx, led_txrx2_tx, led_txrx2_rx};
      assert (leds === data[5:0]) else report_mismatch("LED outputs differ from LEDS");
      check_reg(`E31X_ADDR_LEDS, '1, {26'd0, data[5:0]}, "LEDS readback");
    end
    write_reg(`E31X_ADDR_CTRL, 32'd3);
    assert (cat_reset_n === 1'b0) else report_mismatch("cat_reset_n high with codec_reset");
    check_reg(`E31X_ADDR_CTRL, '1, 32'd3, "CTRL readback");
    write_reg(`E31X_ADDR_CTRL, 32'd1);
    assert (cat_reset_n === 1'b1) else report_mismatch("cat_reset_n stuck low");
  endtask

  // Old bits on the second read, new bits on the third
  task automatic check_status_sync();
    reg_data_t  data;
    logic [5:0] old_bits;
    logic [5:0] new_bits;
    old_bits = {ref_status, tx_pll_lock, rx_pll_lock};
    new_bits = 6'($urandom);
    {ref_status, tx_pll_lock, rx_pll_lock} = new_bits;
    read_reg(`E31X_ADDR_STATUS, data);
    read_reg(`E31X_ADDR_STATUS, data);
    assert (data[11:6] === old_bits) else report_mismatch("status changed before 2 cycles");
    read_reg(`E31X_ADDR_STATUS, data);
    assert (data[11:6] === new_bits) else report_mismatch("status not synced after 2 cycles");
    assert (data[31:12] === '0 && data[5:2] === '0) else report_mismatch("STATUS spare bits");
  endtask

  task automatic drive_rx_samples();
    rx_a_i = sample_t'($urandom);
    rx_a_q = sample_t'($urandom);
    rx_b_i = sample_t'($urandom);
    rx_b_q = sample_t'($urandom);
  endtask

  // Credits stay at or below the buffered words, so none are left over
  task automatic drain_rx();
    int waited;
    waited = 0;
    while (rx_model.size() > 0) begin
      rx_credit = (rx_credits < rx_model.size());
      step();
      waited++;
      if (waited > DRAIN_LIMIT)
        abort_run("receive words were not delivered in time");
    end
    rx_credit = 1'b0;
    assert (rx_credits == 0) else report_mismatch("credits left after receive drain");
  endtask

  task automatic run_rx_stream(input int words);
    int sent;
    sent = 0;
    while (sent < words) begin
      rx_stb    = (rx_model.size() < RX_DEPTH) && ($urandom_range(0, 2) != 0);
      rx_credit = (rx_credits < rx_model.size()) && ($urandom_range(0, 1) == 1);
      drive_rx_samples();
      if (rx_stb)
        sent++;
      step();
    end
    rx_stb = 1'b0;
    drain_rx();
    check_reg(`E31X_ADDR_STATUS, 32'h1, 32'd0, "overflow flag set without overflow");
  endtask

  task automatic run_rx_overflow();
    repeat (RX_DEPTH + 2) begin
      rx_stb = 1'b1;
      drive_rx_samples();
      step();
    end
    rx_stb = 1'b0;
    check_reg(`E31X_ADDR_STATUS, 32'h1, 32'h1, "overflow flag not set");
    drain_rx();
    write_reg(`E31X_ADDR_STATUS, 32'h1);
    check_reg(`E31X_ADDR_STATUS, 32'h1, 32'd0, "overflow flag not cleared");
  endtask

  // Random sends and strobes, then strobes until the buffer is empty
  task automatic run_tx_stream(input int cycles);
    repeat (cycles) begin
      tx_valid = (tx_credits > 0) && ($urandom_range(0, 1) == 1);
      tx_data  = {$urandom, $urandom};
      if (tx_valid)
        tx_credits--;
      tx_stb = (tx_model.size() > 0) && ($urandom_range(0, 2) == 0);
      step();
    end
    tx_valid = 1'b0;
    while (tx_model.size() > 0) begin
      tx_stb = 1'b1;
      step();
    end
    tx_stb = 1'b0;
  endtask

  task automatic run_tx_underrun();
    check_reg(`E31X_ADDR_STATUS, 32'h2, 32'd0, "underrun flag set too early");
    // One strobe on the empty buffer
    tx_stb = 1'b1;
    step();
    tx_stb = 1'b0;
    step();
    check_reg(`E31X_ADDR_STATUS, 32'h2, 32'h2, "underrun flag not set");
    assert (tx_credits == TX_DEPTH) else report_mismatch("transmit credits not all returned");
    write_reg(`E31X_ADDR_STATUS, 32'h2);
    check_reg(`E31X_ADDR_STATUS, 32'h2, 32'd0, "underrun flag not cleared");
  endtask

  initial begin
    void'($urandom(32'h5cd93662));
    reset       = 1'b1;
    reg_wr_en   = 1'b0;
    reg_wr_addr = '0;
    reg_wr_data = '0;
    reg_rd_en   = 1'b0;
    reg_rd_addr = '0;
    rx_stb      = 1'b0;
    rx_a_i      = '0;
    rx_a_q      = '0;
    rx_b_i      = '0;
    rx_b_q      = '0;
    rx_credit   = 1'b0;
    tx_valid    = 1'b0;
    tx_data     = '0;
    tx_stb      = 1'b0;
    ref_status  = '0;
    tx_pll_lock = 1'b0;
    rx_pll_lock = 1'b0;
    gps_pps     = 1'b0;
    repeat (2) @(posedge bus_clk);
    #1;
    assert (cat_reset_n === 1'b0) else report_mismatch("cat_reset_n high during reset");
    reset = 1'b0;
    check_regs_and_leds();
    repeat (8) check_status_sync();
    run_rx_stream(RX_WORDS);
    write_reg(`E31X_ADDR_CTRL, 32'd0);
    run_rx_stream(RX_WORDS / 4);
    write_reg(`E31X_ADDR_CTRL, 32'd1);
    run_rx_overflow();
    run_tx_stream(TX_CYCLES);
    write_reg(`E31X_ADDR_CTRL, 32'd0);
    run_tx_stream(TX_CYCLES / 4);
    write_reg(`E31X_ADDR_CTRL, 32'd1);
    run_tx_underrun();
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
src/e31x_pkg.sv
src/e31x_ctrl_regs.sv
src/e31x_status_sync.sv
src/e31x_rx_packer.sv
src/e31x_tx_unpacker.sv
src/e31x_radio_glue.sv
testbench/e31x_tb.sv

// ==== Makefile ====
# Verilator build and run of the radio glue testbench
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= e31x_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
